/* hw/pipeCpu_macros.svh */
`ifndef PIPECPU_MACROS_SVH
`define PIPECPU_MACROS_SVH

// Datapath and register file
`define PIPECPU_DATA_W 16
`define PIPECPU_REG_CNT 16

// Program memory words, loaded through the program port
`define PIPECPU_PROG_DEPTH 256

// Internal data memory words
`define PIPECPU_DMEM_DEPTH 64

// Stores at or above this address leave the core as output beats
`define PIPECPU_OUT_BASE 16'hFF00

// Most credits the output port can hold
`define PIPECPU_CREDIT_MAX 4

`endif

/* hw/pipeCpuPkg.sv */
`include "pipeCpu_macros.svh"

package pipeCpuPkg;

	typedef logic [`PIPECPU_DATA_W-1:0] dataWord_t;
	typedef logic [$clog2(`PIPECPU_REG_CNT)-1:0] regIdx_t;
	typedef logic [$clog2(`PIPECPU_PROG_DEPTH)-1:0] progAddr_t;
	typedef logic [31:0] instrWord_t;

	typedef enum logic [4:0]
	{
		ADD = 5'd0,
		SUB = 5'd1,
		ADDI = 5'd2,
		SUBI = 5'd3,
		MLT = 5'd4,
		MLTI = 5'd5,
		AND = 5'd6,
		OR = 5'd7,
		ANDI = 5'd8,
		ORI = 5'd9,
		SLR = 5'd10,
		SLL = 5'd11,
		LDR = 5'd12,
		STR = 5'd13,
		BNE = 5'd14,
		BEQ = 5'd15,
		J = 5'd16,
		CMP = 5'd17,
		NOP = 5'd31
	} opcode_t;

	typedef enum logic [1:0]
	{
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP
	} branchKind_t;

	typedef enum logic [1:0]
	{
		IDLE,
		RUNNING,
		DRAINING
	} runState_t;

	// Writeback source
	localparam logic [1:0] SEL_ALU = 2'd0;
	localparam logic [1:0] SEL_ALU_IMM = 2'd1;
	localparam logic [1:0] SEL_MEM = 2'd2;

	typedef struct packed
	{
		logic bSelector;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic [1:0] regSelector;
		logic flagWrite;
		branchKind_t branchKind;
		opcode_t aluOp;
	} ctrlBundle_t;

	typedef struct packed
	{
		logic valid;
		instrWord_t instr;
		progAddr_t pc;
	} decodeReg_t;

	typedef struct packed
	{
		logic valid;
		ctrlBundle_t ctrl;
		dataWord_t opA;
		dataWord_t opB;
		dataWord_t storeData;
		regIdx_t rd;
		dataWord_t imm;
		progAddr_t target;
	} execReg_t;

	typedef struct packed
	{
		logic [7:0] port;
		dataWord_t data;
	} outBeat_t;

endpackage

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
(
	input pipeCpuPkg::opcode_t opcode,
	output pipeCpuPkg::ctrlBundle_t ctrl,
	input pipeCpuPkg::ctrlBundle_t execCtrl,
	input logic execValid,
	input logic zeroFlag,
	output logic branchTaken
);
	import pipeCpuPkg::*;

	// Decode side, for the instruction sitting in decodeReg
	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = NOP;
		ctrl.branchKind = BR_NONE;
		case (opcode)
			ADD, SUB, MLT, AND, OR:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regSelector = SEL_ALU;
				ctrl.aluOp = opcode;
			end
			ADDI, SUBI, MLTI, ANDI, ORI, SLR, SLL:
			begin
				ctrl.bSelector = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.regSelector = SEL_ALU_IMM;
				ctrl.aluOp = opcode;
			end
			CMP:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite = 1'b1;
				ctrl.regSelector = SEL_ALU;
				ctrl.aluOp = CMP;
			end
			LDR:
			begin
				ctrl.bSelector = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.regSelector = SEL_MEM;
				ctrl.aluOp = ADD;
			end
			STR:
			begin
				ctrl.bSelector = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.regSelector = SEL_MEM;
				ctrl.aluOp = ADD;
			end
			BNE:
				ctrl.branchKind = BR_NE;
			BEQ:
				ctrl.branchKind = BR_EQ;
			J:
				ctrl.branchKind = BR_JUMP;
			// NOP and every unused code fall through as a bubble
			default:
			begin
			end
		endcase
	end

	// Branches resolve in execute against the flag left by an earlier CMP
	always_comb
	begin
		branchTaken = 1'b0;
		if (execValid)
		begin
			case (execCtrl.branchKind)
				BR_EQ:
					branchTaken = zeroFlag;
				BR_NE:
					branchTaken = !zeroFlag;
				BR_JUMP:
					branchTaken = 1'b1;
				default:
					branchTaken = 1'b0;
			endcase
		end
	end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module regFile
(
	input logic clk,
	input logic rst,
	input pipeCpuPkg::regIdx_t readA,
	input pipeCpuPkg::regIdx_t readB,
	output pipeCpuPkg::dataWord_t dataA,
	output pipeCpuPkg::dataWord_t dataB,
	input logic writeEn,
	input pipeCpuPkg::regIdx_t writeIdx,
	input pipeCpuPkg::dataWord_t writeData
);
	import pipeCpuPkg::*;

	dataWord_t regs [`PIPECPU_REG_CNT];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `PIPECPU_REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
			regs[writeIdx] <= writeData;
	end

	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu
(
	input pipeCpuPkg::opcode_t aluOp,
	input pipeCpuPkg::dataWord_t a,
	input pipeCpuPkg::dataWord_t b,
	output pipeCpuPkg::dataWord_t result,
	output logic zero
);
	import pipeCpuPkg::*;

	always_comb
	begin
		case (aluOp)
			ADD, ADDI:
				result = a + b;
			// CMP is a subtract whose main use is the zero output
			SUB, SUBI, CMP:
				result = a - b;
			// Only the low half of the product is kept
			MLT, MLTI:
				result = a * b;
			AND, ANDI:
				result = a & b;
			OR, ORI:
				result = a | b;
			SLR:
				result = a >> b[3:0];
			SLL:
				result = a << b[3:0];
			default:
				result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module fetchUnit
(
	input logic clk,
	input logic rst,
	input logic progWe,
	input pipeCpuPkg::progAddr_t progAddr,
	input pipeCpuPkg::instrWord_t progData,
	input logic fetchEn,
	input logic flush,
	input logic redirect,
	input pipeCpuPkg::progAddr_t target,
	output pipeCpuPkg::decodeReg_t decodeReg
);
	import pipeCpuPkg::*;

	instrWord_t progMem [`PIPECPU_PROG_DEPTH];
	progAddr_t pc;

	always_ff @(posedge clk)
	begin
		if (progWe)
			progMem[progAddr] <= progData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			decodeReg.valid <= 1'b0;
		end
		else
		begin
			// A redirect wins even while fetch is held
			if (redirect)
				pc <= target;
			else if (fetchEn)
				pc <= pc + 1'b1;

			if (fetchEn)
			begin
				decodeReg.instr <= progMem[pc];
				decodeReg.pc <= pc;
			end

			if (flush)
				decodeReg.valid <= 1'b0;
			else if (fetchEn)
				decodeReg.valid <= 1'b1;
		end
	end

endmodule

/* hw/pipelineControl.sv */
`timescale 1ns/1ps

module pipelineControl
(
	input logic clk,
	input logic rst,
	input logic run,
	input logic execStore,
	input logic creditEmpty,
	input logic branchTaken,
	output logic fetchEn,
	output logic decodeEn,
	output logic execEn,
	output logic flush
);
	import pipeCpuPkg::*;

	runState_t state;
	runState_t stateNext;
	logic drainHalf;
	logic stall;
	logic active;

	// A port store with no credit freezes every stage in place
	assign stall = execStore && creditEmpty;
	assign active = (state != IDLE);

	assign fetchEn = (state == RUNNING) && !stall;
	assign decodeEn = active && !stall;
	assign execEn = active && !stall;

	// While draining the decode register is emptied behind each consumed instruction
	assign flush = branchTaken || ((state == DRAINING) && !stall);

	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
				if (run)
					stateNext = RUNNING;
			RUNNING:
				if (!run)
					stateNext = DRAINING;
			DRAINING:
				if (run)
					stateNext = RUNNING;
				else if (!stall && drainHalf)
					stateNext = IDLE;
			default:
				stateNext = IDLE;
		endcase
	end

	// Two unstalled drain cycles empty both pipeline registers
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			drainHalf <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (state != DRAINING)
				drainHalf <= 1'b0;
			else if (!stall)
				drainHalf <= 1'b1;
		end
	end

endmodule

/* hw/outPort.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module outPort
(
	input logic clk,
	input logic rst,
	input logic outCredit,
	input logic storeReq,
	input pipeCpuPkg::dataWord_t storeAddr,
	input pipeCpuPkg::dataWord_t storeData,
	output logic creditEmpty,
	output logic outValid,
	output pipeCpuPkg::outBeat_t outBeat
);
	localparam int CREDIT_W = $clog2(`PIPECPU_CREDIT_MAX + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`PIPECPU_CREDIT_MAX);

	logic [CREDIT_W-1:0] creditCnt;
	logic creditFull;
	logic send;

	assign creditEmpty = (creditCnt == '0);
	assign creditFull = (creditCnt == CREDIT_MAX);
	assign send = storeReq && !creditEmpty;

	// A credit and a beat in the same cycle cancel out
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			creditCnt <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= send;
			if (send && !outCredit)
				creditCnt <= creditCnt - 1'b1;
			else if (outCredit && !send && !creditFull)
				creditCnt <= creditCnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (send)
		begin
			outBeat.port <= storeAddr[7:0];
			outBeat.data <= storeData;
		end
	end

endmodule

/* hw/pipeCpu.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module pipeCpu
(
	input logic clk,
	input logic rst,
	input logic run,
	input logic progWe,
	input pipeCpuPkg::progAddr_t progAddr,
	input pipeCpuPkg::instrWord_t progData,
	input logic outCredit,
	output logic outValid,
	output pipeCpuPkg::outBeat_t outBeat
);
	import pipeCpuPkg::*;

	localparam int DMEM_AW = $clog2(`PIPECPU_DMEM_DEPTH);

	decodeReg_t decodeReg;
	execReg_t execReg;
	execReg_t execNext;
	ctrlBundle_t decodeCtrl;
	opcode_t decodeOp;
	regIdx_t rsIdx;
	regIdx_t rtIdx;
	dataWord_t rfA;
	dataWord_t rfB;
	dataWord_t fwdA;
	dataWord_t fwdB;
	dataWord_t aluB;
	dataWord_t aluResult;
	dataWord_t memData;
	dataWord_t wbData;
	dataWord_t dataMem [`PIPECPU_DMEM_DEPTH];
	logic aluZero;
	logic zeroFlag;
	logic branchTaken;
	logic fetchEn;
	logic decodeEn;
	logic execEn;
	logic flush;
	logic execCommit;
	logic execFwd;
	logic portAddr;
	logic portStore;
	logic creditEmpty;
	logic runQ;
	logic restart;

	// Rising run restarts the program from address 0
	always_ff @(posedge clk)
	begin
		if (rst)
			runQ <= 1'b0;
		else
			runQ <= run;
	end

	assign restart = run && !runQ;

	fetchUnit fetchUnit_i
	(
		.clk(clk),
		.rst(rst),
		.progWe(progWe && !run),
		.progAddr(progAddr),
		.progData(progData),
		.fetchEn(fetchEn),
		.flush(flush),
		.redirect(branchTaken || restart),
		.target(branchTaken ? execReg.target : progAddr_t'(0)),
		.decodeReg(decodeReg)
	);

	////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////

	assign decodeOp = opcode_t'(decodeReg.instr[31:27]);
	assign rsIdx = decodeReg.instr[22:19];
	assign rtIdx = decodeReg.instr[18:15];

	regFile regFile_i
	(
		.clk(clk),
		.rst(rst),
		.readA(rsIdx),
		.readB(rtIdx),
		.dataA(rfA),
		.dataB(rfB),
		.writeEn(execCommit && execReg.ctrl.regWrite),
		.writeIdx(execReg.rd),
		.writeData(wbData)
	);

	// The execute result bypasses the register file one stage early
	assign execFwd = execReg.valid && execReg.ctrl.regWrite;
	assign fwdA = (execFwd && execReg.rd == rsIdx) ? wbData : rfA;
	assign fwdB = (execFwd && execReg.rd == rtIdx) ? wbData : rfB;

	always_comb
	begin
		execNext.valid = decodeReg.valid && !branchTaken;
		execNext.ctrl = decodeCtrl;
		execNext.opA = fwdA;
		execNext.opB = fwdB;
		execNext.storeData = fwdB;
		execNext.rd = decodeReg.instr[26:23];
		execNext.imm = dataWord_t'($signed(decodeReg.instr[14:0]));
		execNext.target = decodeReg.instr[7:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			execReg.valid <= 1'b0;
		else if (decodeEn)
			execReg <= execNext;
	end

	////////////////////////////////////////////////////////////////////
	// Execute and writeback
	////////////////////////////////////////////////////////////////////

	assign execCommit = execReg.valid && execEn;
	assign aluB = execReg.ctrl.bSelector ? execReg.imm : execReg.opB;

	alu alu_i
	(
		.aluOp(execReg.ctrl.aluOp),
		.a(execReg.opA),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	controlUnit controlUnit_i
	(
		.opcode(decodeOp),
		.ctrl(decodeCtrl),
		.execCtrl(execReg.ctrl),
		.execValid(execCommit),
		.zeroFlag(zeroFlag),
		.branchTaken(branchTaken)
	);

	assign portAddr = (aluResult >= `PIPECPU_OUT_BASE);
	assign portStore = execReg.valid && execReg.ctrl.memWrite && portAddr;
	assign memData = execReg.ctrl.memRead ? dataMem[aluResult[DMEM_AW-1:0]] : '0;
	assign wbData = (execReg.ctrl.regSelector == SEL_MEM) ? memData : aluResult;

	always_ff @(posedge clk)
	begin
		if (execCommit && execReg.ctrl.memWrite && !portAddr)
			dataMem[aluResult[DMEM_AW-1:0]] <= execReg.storeData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			zeroFlag <= 1'b0;
		else if (execCommit && execReg.ctrl.flagWrite)
			zeroFlag <= aluZero;
	end

	pipelineControl pipelineControl_i
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.execStore(portStore),
		.creditEmpty(creditEmpty),
		.branchTaken(branchTaken),
		.fetchEn(fetchEn),
		.decodeEn(decodeEn),
		.execEn(execEn),
		.flush(flush)
	);

	outPort outPort_i
	(
		.clk(clk),
		.rst(rst),
		.outCredit(outCredit),
		.storeReq(portStore && execEn),
		.storeAddr(aluResult),
		.storeData(execReg.storeData),
		.creditEmpty(creditEmpty),
		.outValid(outValid),
		.outBeat(outBeat)
	);

endmodule

/* tb/pipeCpu_assertions.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module pipeCpuAssertions
(
	input logic clk,
	input logic rst,
	input logic outValid,
	input logic flush,
	input logic decodeValid,
	input logic [$clog2(`PIPECPU_CREDIT_MAX + 1)-1:0] creditCnt,
	input pipeCpuPkg::runState_t runState
);
	import pipeCpuPkg::*;

	int errorCount = 0;

	// A flushed slot never reaches decode
	flushEmptiesDecode: assert property (@(posedge clk) disable iff (rst)
		flush |=> !decodeValid)
	else
	begin
		$error("flush was not followed by an empty decode register");
		errorCount = errorCount + 1;
	end

	// Every beat was paid for by a credit held in the cycle it was sent
	beatNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		outValid |-> ($past(creditCnt) != 0))
	else
	begin
		$error("an output beat left the core with no credit");
		errorCount = errorCount + 1;
	end

	creditBounded: assert property (@(posedge clk) disable iff (rst)
		creditCnt <= `PIPECPU_CREDIT_MAX)
	else
	begin
		$error("credit count went above its limit");
		errorCount = errorCount + 1;
	end

	resetState: assert property (@(posedge clk)
		rst |=> (!outValid && !flush && runState == IDLE))
	else
	begin
		$error("core did not come out of reset idle and quiet");
		errorCount = errorCount + 1;
	end

endmodule

/* tb/pipeCpu_tb.sv */
`timescale 1ns/1ps
`include "pipeCpu_macros.svh"

module pipeCpu_tb;
	import pipeCpuPkg::*;

	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic rst;
	logic run;
	logic progWe;
	progAddr_t progAddr;
	instrWord_t progData;
	logic outCredit;
	logic outValid;
	outBeat_t outBeat;

	outBeat_t expected [$];
	outBeat_t expBeat;
	dataWord_t regModel [`PIPECPU_REG_CNT];
	dataWord_t dmemModel [`PIPECPU_DMEM_DEPTH];
	logic zeroModel;
	int asmPc;
	int cycleCount = 0;
	int holdCycles = 0;
	bit backPressure = 1'b0;
	integer seed = 35;

	pipeCpu pipeCpu_i
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.outCredit(outCredit),
		.outValid(outValid),
		.outBeat(outBeat)
	);

	bind pipeCpu pipeCpuAssertions checks_i
	(
		.clk(clk),
		.rst(rst),
		.outValid(outValid),
		.flush(flush),
		.decodeValid(decodeReg.valid),
		.creditCnt(outPort_i.creditCnt),
		.runState(pipelineControl_i.state)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Consumer side, either a credit every cycle or long random gaps
	initial
	begin
		outCredit = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (holdCycles > 0)
			begin
				outCredit = 1'b0;
				holdCycles = holdCycles - 1;
			end
			else
			begin
				outCredit = 1'b1;
				if (backPressure)
					holdCycles = {$random(seed)} % 40;
			end
		end
	end

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Assembler with a reference model of the instruction rules
	//////////////////////////////////////////////////////////////////////

	function automatic instrWord_t encode(opcode_t op, int rd, int rs, int rt, int imm);
		return {op, 4'(rd), 4'(rs), 4'(rt), 15'(imm)};
	endfunction

	function automatic dataWord_t signExtend(int imm);
		logic [14:0] imm15;
		imm15 = imm[14:0];
		return {imm15[14], imm15};
	endfunction

	function automatic dataWord_t modelAlu(opcode_t op, dataWord_t a, dataWord_t b);
		case (op)
			ADD, ADDI:
				return a + b;
			SUB, SUBI, CMP:
				return a - b;
			MLT, MLTI:
				return a * b;
			AND, ANDI:
				return a & b;
			OR, ORI:
				return a | b;
			SLR:
				return a >> b[3:0];
			SLL:
				return a << b[3:0];
			default:
				return '0;
		endcase
	endfunction

	task automatic putWord(input instrWord_t word);
		progWe = 1'b1;
		progAddr = progAddr_t'(asmPc);
		progData = word;
		@(posedge clk);
		#1;
		progWe = 1'b0;
		asmPc++;
	endtask

	task automatic emitAlu(input opcode_t op, input int rd, input int rs, input int rt,
		input int imm);
		dataWord_t b;
		dataWord_t r;
		b = (op inside {ADDI, SUBI, MLTI, ANDI, ORI, SLR, SLL}) ? signExtend(imm) : regModel[rt];
		r = modelAlu(op, regModel[rs], b);
		regModel[rd] = r;
		if (op == CMP)
			zeroModel = (r == '0);
		putWord(encode(op, rd, rs, rt, imm));
	endtask

	task automatic storeWord(input int rs, input int rt, input int imm);
		dataWord_t addr;
		addr = regModel[rs] + signExtend(imm);
		dmemModel[addr % `PIPECPU_DMEM_DEPTH] = regModel[rt];
		putWord(encode(STR, 0, rs, rt, imm));
	endtask

	task automatic loadWord(input int rd, input int rs, input int imm);
		dataWord_t addr;
		addr = regModel[rs] + signExtend(imm);
		regModel[rd] = dmemModel[addr % `PIPECPU_DMEM_DEPTH];
		putWord(encode(LDR, rd, rs, 0, imm));
	endtask

	// r0 stays zero, so the immediate alone forms the port address
	task automatic storeToPort(input int rt, input int port, input bit reached);
		outBeat_t beat;
		beat.port = 8'(port);
		beat.data = regModel[rt];
		if (reached)
			expected.push_back(beat);
		putWord(encode(STR, 0, 0, rt, 'h7F00 + port));
	endtask

	// Branch past two port stores that only show up when it falls through
	task automatic branchOver(input opcode_t op);
		bit taken;
		taken = (op == J) || (op == BEQ && zeroModel) || (op == BNE && !zeroModel);
		putWord(encode(op, 0, 0, 0, asmPc + 3));
		for (int i = 0; i < 2; i++)
			storeToPort(1, asmPc, !taken);
	endtask

	task automatic resetCore();
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		asmPc = 0;
		zeroModel = 1'b0;
		for (int i = 0; i < `PIPECPU_REG_CNT; i++)
			regModel[i] = '0;
	endtask

	task automatic runProgram(input bit overwrite);
		putWord(encode(J, 0, 0, 0, asmPc));
		run = 1'b1;
		if (overwrite)
		begin
			for (int i = 4; i < 24; i++)
			begin
				progWe = 1'b1;
				progAddr = progAddr_t'(i);
				progData = encode(STR, 0, 0, 0, 'h7F00 + (i ^ 'hFF));
				@(posedge clk);
				#1;
			end
			progWe = 1'b0;
		end
		while (expected.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
		// Extra cycles so a stray beat from a flushed slot would surface
		repeat (12) @(posedge clk);
		#1;
		run = 1'b0;
		repeat (4) @(posedge clk);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!rst && outValid)
		begin
			if (expected.size() == 0)
			begin
				$display("Output beat %h arrived when no beat was expected", outBeat);
				abortRun();
			end
			else
			begin
				expBeat = expected.pop_front();
				assert (outBeat == expBeat)
				else
				begin
					$display("CHECK FAILED: outBeat = %h, expected %h", outBeat, expBeat);
					abortRun();
				end
			end
		end
	end

	always @(negedge clk)
	begin
		cycleCount++;
		if (cycleCount >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, expected output beats are missing", MAX_CYCLES);
			abortRun();
		end
		else if (pipeCpu_i.checks_i.errorCount != 0)
		begin
			$display("A bound assertion on the core failed");
			abortRun();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Programs
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;

		// Arithmetic, logic and shifts with back-to-back dependencies
		resetCore();
		emitAlu(ADDI, 1, 0, 0, 1234);
		emitAlu(ADDI, 2, 0, 0, -3);
		emitAlu(ADD, 3, 1, 2, 0);
		storeToPort(3, 'h01, 1'b1);
		emitAlu(SUB, 4, 3, 1, 0);
		emitAlu(MLT, 5, 4, 1, 0);
		storeToPort(5, 'h02, 1'b1);
		emitAlu(MLTI, 6, 5, 0, 77);
		emitAlu(AND, 7, 6, 2, 0);
		storeToPort(7, 'h03, 1'b1);
		emitAlu(OR, 8, 7, 1, 0);
		emitAlu(ANDI, 9, 8, 0, 'h0FF0);
		emitAlu(ORI, 10, 9, 0, 'h3001);
		storeToPort(10, 'h04, 1'b1);
		emitAlu(SLL, 11, 10, 0, 3);
		emitAlu(SLR, 12, 11, 0, 5);
		emitAlu(SUBI, 13, 12, 0, 100);
		storeToPort(13, 'h05, 1'b1);
		storeToPort(12, 'h06, 1'b1);
		runProgram(1'b1);

		// Store then load of the same word, and a load feeding the next instruction
		resetCore();
		emitAlu(ADDI, 1, 0, 0, 'h1357);
		emitAlu(ADDI, 2, 0, 0, 20);
		storeWord(2, 1, 5);
		loadWord(3, 2, 5);
		storeToPort(3, 'h10, 1'b1);
		emitAlu(ADDI, 4, 3, 0, -1);
		storeWord(0, 4, 7);
		loadWord(5, 0, 7);
		emitAlu(ADD, 6, 5, 5, 0);
		storeToPort(6, 'h11, 1'b1);
		runProgram(1'b0);

		// Branches on both values of the zero flag
		resetCore();
		emitAlu(ADDI, 1, 0, 0, 5);
		emitAlu(ADDI, 2, 0, 0, 5);
		emitAlu(ADDI, 3, 0, 0, 9);
		storeToPort(1, 'h20, 1'b1);
		emitAlu(CMP, 4, 1, 2, 0);
		branchOver(BEQ);
		branchOver(BNE);
		emitAlu(CMP, 4, 1, 3, 0);
		storeToPort(4, 'h22, 1'b1);
		branchOver(BEQ);
		branchOver(BNE);
		branchOver(J);
		storeToPort(3, 'h21, 1'b1);
		runProgram(1'b0);

		// Port stores under long credit gaps
		resetCore();
		backPressure = 1'b1;
		for (int k = 0; k < 12; k++)
		begin
			emitAlu(ADDI, 1, 1, 0, k * 37 + 1);
			storeToPort(1, k, 1'b1);
			storeToPort(1, k + 'h40, 1'b1);
		end
		runProgram(1'b0);

		if (expected.size() == 0 && pipeCpu_i.checks_i.errorCount == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("Beats were left over or an assertion failed before the end of the run");
			abortRun();
		end
	end

endmodule

/* pipeCpu.f */
+incdir+hw
hw/pipeCpuPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/alu.sv
hw/fetchUnit.sv
hw/pipelineControl.sv
hw/outPort.sv
hw/pipeCpu.sv
tb/pipeCpu_assertions.sv
tb/pipeCpu_tb.sv
